// File: mac_settings.svh
// mac memory glue settings
// sizes, region codes and counter widths shared by the memory-side blocks

`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// ==================================================
// floppy image sizes
// ==================================================

// sizes count 16-bit words, compared against the word address at download end
// 819200 byte double-sided image
`define DISK_DS_WORDS 24'd409600
// 409600 byte single-sided image
`define DISK_SS_WORDS 24'd204800

// ==================================================
// address map and reset
// ==================================================

// cpu address bits 23..21 of the autovectored io space
`define IO_REGION 3'b111
// reset stretch counter, expires after 2**width 8 MHz enables
`define RST_CNT_W 8
// sdram prefix of the rom and downloaded image region
`define SDRAM_ROM_PREFIX 4'b0001

`endif

// File: mac_pkg.sv
// mac memory glue package
// shared word, address and floppy state types for the memory side

`default_nettype none

package mac_pkg;

	// ==================================================
	// sdram side
	// ==================================================

	// one sdram data word
	typedef logic [15:0] sdram_word_t;

	// sdram word address, 32M words max
	typedef logic [24:0] sdram_addr_t;

	// ==================================================
	// download side
	// ==================================================

	// mapped download word address, rom plus both disk image areas
	typedef logic [20:0] dio_addr_t;

	// per-drive floppy state
	// bit 0 is the internal drive, bit 1 the external drive
	typedef struct packed {
		// double-sided image inserted
		logic [1:0] ds;
		// single-sided image inserted
		logic [1:0] ss;
	} disk_state_t;

endpackage

`default_nettype wire

// File: dl_req_if.sv
// download request interface
// carries a captured download word from the loader to the sdram selector

`timescale 1ns/1ps
`default_nettype none

interface dl_req_if
	import mac_pkg::*;
	();

	// mapped word address inside the rom and disk image region
	dio_addr_t   addr;
	// byte-swapped download word
	sdram_word_t data;
	// write pending for the current bus slot
	logic        write;
	// download active and dio bus slot granted
	logic        cycle;

	// loader side drives the request
	modport loader (
		output addr,
		output data,
		output write,
		output cycle
	);

	// selector side only reads it
	modport selector (
		input addr,
		input data,
		input write,
		input cycle
	);

endinterface

`default_nettype wire

// File: reset_sequencer.sv
// machine reset sequencer
// holds the machine in reset for a counted stretch of 8 MHz enables
// and latches the model and memory size choices during that stretch

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module reset_sequencer (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic clk8_en_p,
	input  logic reset_req,
	input  logic cpu_reset_out_n,
	input  logic model_sel,
	input  logic mem_sel,
	output logic mac_reset_n,
	output logic model_se,
	output logic mem_4mb
);

	// stretch counter, reloaded while any reset source is active
	logic [`RST_CNT_W-1:0] rst_cnt;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rst_cnt     <= '1;
			mac_reset_n <= 1'b0;
			model_se    <= 1'b0;
			mem_4mb     <= 1'b0;
		end else if (clk8_en_p) begin
			if (reset_req || !cpu_reset_out_n) begin
				// host request or cpu reset instruction restarts the stretch
				rst_cnt     <= '1;
				mac_reset_n <= 1'b0;
			end else if (rst_cnt != '0) begin
				rst_cnt  <= rst_cnt - 1'b1;
				// config follows its inputs only while held in reset
				model_se <= model_sel;
				mem_4mb  <= mem_sel;
			end else begin
				mac_reset_n <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: bus_decode.sv
// cpu bus acknowledge decode
// generates dtack and vpa for the 68000 bus, with dtack held off in turbo
// mode until the memory slot has actually served the access

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module bus_decode (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       mac_reset_n,
	input  logic       cpu_as_n,
	input  logic [2:0] cpu_fc,
	input  logic [2:0] cpu_addr_hi,
	input  logic       cpu_bus_control,
	input  logic       select_rom,
	input  logic       select_ram,
	input  logic       turbo,
	output logic       cpu_dtack_n,
	output logic       cpu_vpa_n
);

	// ==================================================
	// turbo acknowledge enable
	// ==================================================

	logic bus_ctl_d;
	logic turbo_dtack_en;
	logic bus_ctl_rise;
	// access that never touches sdram can be acked at once
	logic no_mem_sel;
	logic in_io;

	assign bus_ctl_rise = cpu_bus_control & ~bus_ctl_d;
	assign no_mem_sel   = ~select_rom & ~select_ram;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bus_ctl_d      <= 1'b0;
			turbo_dtack_en <= 1'b0;
		end else begin
			bus_ctl_d <= cpu_bus_control;
			if (!mac_reset_n) begin
				turbo_dtack_en <= 1'b0;
			end else if (cpu_as_n) begin
				// strobe gone, next access starts unacked
				turbo_dtack_en <= 1'b0;
			end else if (bus_ctl_rise || no_mem_sel) begin
				turbo_dtack_en <= 1'b1;
			end
		end
	end

	// ==================================================
	// acknowledge outputs
	// ==================================================

	assign in_io = (cpu_addr_hi == `IO_REGION);

	// interrupt ack cycles are always autovectored
	assign cpu_vpa_n = (cpu_fc == 3'b111) ? 1'b0 : ~(~cpu_as_n & in_io);

	// io space is acked through vpa, everything else through dtack
	assign cpu_dtack_n = ~(~cpu_as_n & ~in_io) | (turbo & ~turbo_dtack_en);

endmodule

`default_nettype wire

// File: image_loader.sv
// image download loader
// captures download words with a wait handshake against the dio bus slot,
// maps them into the rom and disk image areas and detects floppy images

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module image_loader
	import mac_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  sdram_word_t ioctl_data,
	input  logic        dio_bus_control,
	input  logic [1:0]  disk_eject,
	output logic        ioctl_wait,
	output logic        disk_int_ins,
	output logic        disk_ext_ins,
	output logic [1:0]  disk_sides,
	dl_req_if.loader    dl
);

	// host address counts bytes, sdram counts words
	logic [23:0] word_addr;
	dio_addr_t   map_addr;
	dio_addr_t   dio_a;
	sdram_word_t dio_data;
	logic        dio_write;
	logic        bus_ctl_d;
	logic        download_d;
	disk_state_t disk_st;

	assign word_addr = ioctl_addr[24:1];

	// disk images sit above the os rom at word offsets 0x80000 and 0x100000
	always_comb begin
		if (ioctl_index[1:0] != 2'b00) begin
			map_addr = {ioctl_index[1:0], word_addr[18:0]};
		end else begin
			map_addr = {2'b00, ioctl_index[6], word_addr[17:0]};
		end
	end

	// ==================================================
	// capture and wait handshake
	// ==================================================

	// captured word and address, valid whenever ioctl_wait is high
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			dio_data <= {ioctl_data[7:0], ioctl_data[15:8]};
			dio_a    <= map_addr;
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ioctl_wait <= 1'b0;
			dio_write  <= 1'b0;
			bus_ctl_d  <= 1'b0;
		end else begin
			bus_ctl_d <= dio_bus_control;
			if (ioctl_wr) begin
				ioctl_wait <= 1'b1;
			end
			// write flag only changes between dio slots
			if (!dio_bus_control) begin
				dio_write <= ioctl_wait;
			end
			// slot ended with the write done, release the host
			if (bus_ctl_d && !dio_bus_control && dio_write) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	// ==================================================
	// floppy image detection
	// ==================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			download_d <= 1'b0;
			disk_st    <= '0;
		end else begin
			download_d <= ioctl_download;
			for (int d = 0; d < 2; d++) begin
				// index 1 is the internal drive, index 2 the external one
				if (download_d && !ioctl_download && ioctl_index == 8'(d + 1)) begin
					disk_st.ds[d] <= (word_addr == `DISK_DS_WORDS);
					disk_st.ss[d] <= (word_addr == `DISK_SS_WORDS);
				end
				// eject from the os wins over a finishing download
				if (disk_eject[d]) begin
					disk_st.ds[d] <= 1'b0;
					disk_st.ss[d] <= 1'b0;
				end
			end
		end
	end

	assign disk_int_ins = disk_st.ds[0] | disk_st.ss[0];
	assign disk_ext_ins = disk_st.ds[1] | disk_st.ss[1];
	assign disk_sides   = disk_st.ds;

	// request towards the sdram selector
	assign dl.addr  = dio_a;
	assign dl.data  = dio_data;
	assign dl.write = dio_write;
	assign dl.cycle = ioctl_download & dio_bus_control;

endmodule

`default_nettype wire

// File: sdram_select.sv
// sdram request selector
// picks the download or the machine as sdram request source and forms
// the read data returned to the machine

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module sdram_select
	import mac_pkg::*;
(
	dl_req_if.selector  dl,
	input  logic        model_se,
	input  logic        rom_oe_n,
	input  logic        ram_oe_n,
	input  logic        ram_we_n,
	input  logic        memory_uds_n,
	input  logic        memory_lds_n,
	input  logic [21:0] memory_addr,
	input  sdram_word_t memory_data_out,
	input  logic        dsk_read_ack_int,
	input  logic        dsk_read_ack_ext,
	input  sdram_word_t sdram_out,
	output sdram_addr_t sdram_addr,
	output sdram_word_t sdram_din,
	output logic [1:0]  sdram_ds,
	output logic        sdram_we,
	output logic        sdram_oe,
	output sdram_word_t memory_data_in
);

	logic        dsk_read;
	// disk images are byte wide, so one byte is spread over the word
	sdram_word_t byte_dup;

	assign dsk_read = dsk_read_ack_int | dsk_read_ack_ext;
	assign byte_dup = memory_addr[0] ? {sdram_out[7:0], sdram_out[7:0]}
	                                 : {sdram_out[15:8], sdram_out[15:8]};

	always_comb begin
		if (dl.cycle) begin
			// download owns the slot, full word writes into rom region
			sdram_addr     = {`SDRAM_ROM_PREFIX, dl.addr};
			sdram_din      = dl.data;
			sdram_ds       = 2'b11;
			sdram_we       = dl.write;
			sdram_oe       = 1'b0;
			// all ones keeps the screen black while loading
			memory_data_in = 16'hffff;
		end else begin
			if (!rom_oe_n) begin
				// model selects the plus or se rom bank
				sdram_addr = {`SDRAM_ROM_PREFIX, 2'b00, model_se, memory_addr[18:1]};
			end else begin
				// ram, with disk reads placed in the upper half
				sdram_addr = {3'b000, dsk_read, memory_addr[21:1]};
			end
			sdram_din      = memory_data_out;
			sdram_ds       = {~memory_uds_n, ~memory_lds_n};
			sdram_we       = ~ram_we_n;
			sdram_oe       = ~ram_oe_n | ~rom_oe_n | dsk_read;
			memory_data_in = dsk_read ? byte_dup : sdram_out;
		end
	end

endmodule

`default_nettype wire

// File: mac_memory_top.sv
// mac memory glue top level
// reset stretch, bus acknowledge, image download and sdram request selection

`timescale 1ns/1ps
`default_nettype none

module mac_memory_top
	import mac_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	// reset and configuration
	input  logic        clk8_en_p,
	input  logic        reset_req,
	input  logic        cpu_reset_out_n,
	input  logic        model_sel,
	input  logic        mem_sel,
	output logic        mac_reset_n,
	output logic        model_se,
	output logic        mem_4mb,
	// cpu bus
	input  logic        cpu_as_n,
	input  logic [2:0]  cpu_fc,
	input  logic [2:0]  cpu_addr_hi,
	input  logic        cpu_bus_control,
	input  logic        select_rom,
	input  logic        select_ram,
	input  logic        turbo,
	output logic        cpu_dtack_n,
	output logic        cpu_vpa_n,
	// download bus
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  sdram_word_t ioctl_data,
	input  logic        dio_bus_control,
	output logic        ioctl_wait,
	// floppy state
	input  logic [1:0]  disk_eject,
	output logic        disk_int_ins,
	output logic        disk_ext_ins,
	output logic [1:0]  disk_sides,
	// machine memory requests
	input  logic        rom_oe_n,
	input  logic        ram_oe_n,
	input  logic        ram_we_n,
	input  logic        memory_uds_n,
	input  logic        memory_lds_n,
	input  logic [21:0] memory_addr,
	input  sdram_word_t memory_data_out,
	input  logic        dsk_read_ack_int,
	input  logic        dsk_read_ack_ext,
	output sdram_word_t memory_data_in,
	// sdram controller side
	input  sdram_word_t sdram_out,
	output sdram_addr_t sdram_addr,
	output sdram_word_t sdram_din,
	output logic [1:0]  sdram_ds,
	output logic        sdram_we,
	output logic        sdram_oe
);

	// download request between loader and selector
	dl_req_if dl ();

	reset_sequencer i_reset_seq (.*);

	bus_decode i_bus_decode (.*);

	image_loader i_image_loader (.*);

	sdram_select i_sdram_select (.*);

endmodule

`default_nettype wire

// File: tb_mac_memory_asserts.sv
// memory glue checker
// rebuilds reset, download, floppy, memory and bus state from the bus rules
// and compares it with the top level outputs on every clock

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module tb_mac_memory_asserts
	import mac_pkg::*;
(
	input logic        clk_sys, rst_n, clk8_en_p, reset_req, cpu_reset_out_n,
	input logic        model_sel, mem_sel, mac_reset_n, model_se, mem_4mb,
	input logic        cpu_as_n, cpu_bus_control, select_rom, select_ram, turbo,
	input logic        cpu_dtack_n, cpu_vpa_n,
	input logic [2:0]  cpu_fc, cpu_addr_hi,
	input logic        ioctl_download, ioctl_wr, dio_bus_control, ioctl_wait,
	input logic [7:0]  ioctl_index,
	input logic [24:0] ioctl_addr,
	input sdram_word_t ioctl_data, memory_data_out, memory_data_in, sdram_out, sdram_din,
	input logic [1:0]  disk_eject, disk_sides, sdram_ds,
	input logic        disk_int_ins, disk_ext_ins, sdram_we, sdram_oe,
	input logic        rom_oe_n, ram_oe_n, ram_we_n, memory_uds_n, memory_lds_n,
	input logic        dsk_read_ack_int, dsk_read_ack_ext,
	input logic [21:0] memory_addr,
	input sdram_addr_t sdram_addr
);

	localparam int RST_ENABLES = 1 << `RST_CNT_W;

	// failure count, watched by the testbench top
	int          fails = 0;
	int          en_seen;
	logic        bus_ctl_d, ack_ref, dl_d, dsk_rd;
	logic        model_ref, mem_ref;
	logic [1:0]  ds_ref, ss_ref;
	dio_addr_t   map_ref, dl_addr_ref;
	sdram_word_t dl_data_ref, rd_ref;
	sdram_addr_t mem_addr_ref;
	logic [60:0] mem_exp, dl_exp, mem_act;
	logic [3:0]  disk_exp;
	logic [1:0]  ack_exp;

	// ==================================================
	// reference model
	// ==================================================

	// word address is the byte address without bit 0
	always_comb begin
		if (ioctl_index[1:0] != 2'b00) begin
			map_ref = (dio_addr_t'(ioctl_index[1:0]) << 19) | dio_addr_t'(ioctl_addr[19:1]);
		end else begin
			map_ref = (dio_addr_t'(ioctl_index[6]) << 18) | dio_addr_t'(ioctl_addr[18:1]);
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			en_seen     <= 0;
			model_ref   <= 1'b0;
			mem_ref     <= 1'b0;
			bus_ctl_d   <= 1'b0;
			ack_ref     <= 1'b0;
			dl_d        <= 1'b0;
			ds_ref      <= 2'b00;
			ss_ref      <= 2'b00;
			dl_addr_ref <= '0;
			dl_data_ref <= '0;
		end else begin
			// enables counted since the last one that saw a reset source
			if (clk8_en_p) begin
				if (reset_req || !cpu_reset_out_n) begin
					en_seen <= 0;
				end else if (en_seen < RST_ENABLES) begin
					en_seen   <= en_seen + 1;
					// configuration taken while the machine is still held
					model_ref <= model_sel;
					mem_ref   <= mem_sel;
				end
			end
			bus_ctl_d <= cpu_bus_control;
			if (en_seen < RST_ENABLES || cpu_as_n) begin
				ack_ref <= 1'b0;
			end else if ((cpu_bus_control && !bus_ctl_d) || !(select_rom || select_ram)) begin
				ack_ref <= 1'b1;
			end
			if (ioctl_wr) begin
				dl_addr_ref <= map_ref;
				dl_data_ref <= {ioctl_data[7:0], ioctl_data[15:8]};
			end
			// image size judged at the end of a drive download
			dl_d <= ioctl_download;
			if (dl_d && !ioctl_download && (ioctl_index == 8'd1 || ioctl_index == 8'd2)) begin
				ds_ref[ioctl_index[1]] <= (ioctl_addr[24:1] == `DISK_DS_WORDS);
				ss_ref[ioctl_index[1]] <= (ioctl_addr[24:1] == `DISK_SS_WORDS);
			end
			if (disk_eject[0]) begin
				ds_ref[0] <= 1'b0;
				ss_ref[0] <= 1'b0;
			end
			if (disk_eject[1]) begin
				ds_ref[1] <= 1'b0;
				ss_ref[1] <= 1'b0;
			end
		end
	end

	assign dsk_rd = dsk_read_ack_int | dsk_read_ack_ext;
	assign mem_addr_ref = !rom_oe_n
		? ((sdram_addr_t'(`SDRAM_ROM_PREFIX) << 21) | (sdram_addr_t'(model_ref) << 18)
			| sdram_addr_t'(memory_addr[18:1]))
		: ((sdram_addr_t'(dsk_rd) << 21) | sdram_addr_t'(memory_addr[21:1]));
	// disk reads spread the addressed byte over both halves
	assign rd_ref = dsk_rd
		? 16'(memory_addr[0] ? sdram_out[7:0] : sdram_out[15:8]) * 16'h0101
		: sdram_out;

	assign mem_act  = {sdram_addr, sdram_we, sdram_ds, sdram_oe, sdram_din, memory_data_in};
	assign mem_exp  = {mem_addr_ref, !ram_we_n, ~memory_uds_n, ~memory_lds_n,
		!ram_oe_n || !rom_oe_n || dsk_rd, memory_data_out, rd_ref};
	assign dl_exp   = {`SDRAM_ROM_PREFIX, dl_addr_ref, 1'b1, 2'b11, 1'b0, dl_data_ref, 16'hffff};
	assign disk_exp = {ds_ref[0] | ss_ref[0], ds_ref[1] | ss_ref[1], ds_ref};
	assign ack_exp  = {!(cpu_fc == 3'b111 || (!cpu_as_n && cpu_addr_hi == `IO_REGION)),
		!(!cpu_as_n && cpu_addr_hi != `IO_REGION && !(turbo && !ack_ref))};

	// ==================================================
	// checks
	// ==================================================

	a_reset_stretch: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mac_reset_n == (en_seen >= RST_ENABLES))
	else begin
		fails++;
		$error("FAILED reset_stretch expected %0b actual %0b",
			$sampled(en_seen >= RST_ENABLES), $sampled(mac_reset_n));
	end

	a_config: assert property (@(posedge clk_sys) disable iff (!rst_n)
		{model_se, mem_4mb} == {model_ref, mem_ref})
	else begin
		fails++;
		$error("FAILED config_latch expected %b actual %b",
			$sampled({model_ref, mem_ref}), $sampled({model_se, mem_4mb}));
	end

	a_wait_rise: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |=> ioctl_wait)
	else begin
		fails++;
		$error("FAILED wait_rise expected 1 actual %0b", $sampled(ioctl_wait));
	end

	// a pending word keeps the host waiting until its slot has ended
	a_wait_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wait && !$fell(dio_bus_control) |=> ioctl_wait)
	else begin
		fails++;
		$error("FAILED wait_hold expected 1 actual %0b", $sampled(ioctl_wait));
	end

	a_wait_fall: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(dio_bus_control) && ioctl_wait |=> !ioctl_wait)
	else begin
		fails++;
		$error("FAILED wait_fall expected 0 actual %0b", $sampled(ioctl_wait));
	end

	a_dl_slot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_download && dio_bus_control && ioctl_wait |-> mem_act == dl_exp)
	else begin
		fails++;
		$error("FAILED download_slot expected %h actual %h",
			$sampled(dl_exp), $sampled(mem_act));
	end

	a_disk: assert property (@(posedge clk_sys) disable iff (!rst_n)
		{disk_int_ins, disk_ext_ins, disk_sides} == disk_exp)
	else begin
		fails++;
		$error("FAILED disk_state expected %b actual %b", $sampled(disk_exp),
			$sampled({disk_int_ins, disk_ext_ins, disk_sides}));
	end

	a_mem_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(ioctl_download && dio_bus_control) |-> mem_act == mem_exp)
	else begin
		fails++;
		$error("FAILED memory_request expected %h actual %h",
			$sampled(mem_exp), $sampled(mem_act));
	end

	a_bus_ack: assert property (@(posedge clk_sys) disable iff (!rst_n)
		{cpu_vpa_n, cpu_dtack_n} == ack_exp)
	else begin
		fails++;
		$error("FAILED bus_ack expected %b actual %b",
			$sampled(ack_exp), $sampled({cpu_vpa_n, cpu_dtack_n}));
	end

endmodule

`default_nettype wire

// File: tb_mac_memory.sv
// testbench for the mac memory glue
// runs reset stretch, image download, floppy, memory and bus sequences
// while the bound checker compares every clock

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module tb_mac_memory
	import mac_pkg::*;
();

	// reset stretch near 1040 cycles plus roughly 250 of traffic
	localparam int TIMEOUT = 3000;

	logic        clk_sys, rst_n, clk8_en_p, reset_req, cpu_reset_out_n;
	logic        model_sel, mem_sel, mac_reset_n, model_se, mem_4mb;
	logic        cpu_as_n, cpu_bus_control, select_rom, select_ram, turbo;
	logic        cpu_dtack_n, cpu_vpa_n;
	logic [2:0]  cpu_fc, cpu_addr_hi;
	logic        ioctl_download, ioctl_wr, dio_bus_control, ioctl_wait;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	sdram_word_t ioctl_data, memory_data_out, memory_data_in, sdram_out, sdram_din;
	logic [1:0]  disk_eject, disk_sides, sdram_ds;
	logic        disk_int_ins, disk_ext_ins, sdram_we, sdram_oe;
	logic        rom_oe_n, ram_oe_n, ram_we_n, memory_uds_n, memory_lds_n;
	logic        dsk_read_ack_int, dsk_read_ack_ext;
	logic [21:0] memory_addr;
	sdram_addr_t sdram_addr;

	integer      seed;
	int          cycles;
	logic [1:0]  en_div;
	logic [31:0] r;

	mac_memory_top i_dut (.*);

	bind mac_memory_top tb_mac_memory_asserts i_asserts (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// 8 MHz enable, one clock in four
	always @(posedge clk_sys) begin
		en_div    <= en_div + 2'd1;
		clk8_en_p <= (en_div == 2'd3);
	end

	// ==================================================
	// watchdog
	// ==================================================

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (i_dut.i_asserts.fails != 0) begin
			$display("a check in the bound assertion module failed");
			$display("sim failed");
			$fatal(1, "stopped at the first failing check");
		end else if (cycles >= TIMEOUT) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT);
			$display("sim failed");
			$fatal(1, "stopped by the cycle limit");
		end
	end

	task automatic ticks(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	// returns at a falling edge once ioctl_wait shows the wanted level
	task automatic wait_for_wait(input logic level);
		do @(negedge clk_sys); while (ioctl_wait !== level);
	endtask

	// one host word, then a dio slot that carries it to sdram
	task automatic send_word(input logic [7:0] index, input logic [24:0] byte_addr,
		input sdram_word_t data);
		@(posedge clk_sys);
		ioctl_index <= index;
		ioctl_addr  <= byte_addr;
		ioctl_data  <= data;
		ioctl_wr    <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		wait_for_wait(1'b1);
		// write flag is taken while the slot is still closed
		ticks(2);
		dio_bus_control <= 1'b1;
		ticks(3);
		dio_bus_control <= 1'b0;
		wait_for_wait(1'b0);
	endtask

	// a few random words, then the final word address that sizes the image
	task automatic download(input logic [7:0] index, input int words, input int last_word);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		for (int i = 0; i < words; i++) begin
			send_word(index, 25'($random(seed)), 16'($random(seed)));
		end
		send_word(index, 25'(last_word) << 1, 16'($random(seed)));
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		ticks(3);
	endtask

	task automatic eject(input logic [1:0] drives);
		@(posedge clk_sys);
		disk_eject <= drives;
		@(posedge clk_sys);
		disk_eject <= 2'b00;
		ticks(2);
	endtask

	// ==================================================
	// test sequence
	// ==================================================

	initial begin
		seed             = 32'hc5fb;
		cycles           = 0;
		en_div           = 2'd0;
		clk8_en_p        = 1'b0;
		rst_n            = 1'b0;
		reset_req        = 1'b1;
		cpu_reset_out_n  = 1'b1;
		model_sel        = 1'b1;
		mem_sel          = 1'b1;
		cpu_as_n         = 1'b1;
		cpu_fc           = 3'b101;
		cpu_addr_hi      = 3'b000;
		cpu_bus_control  = 1'b0;
		select_rom       = 1'b0;
		select_ram       = 1'b0;
		turbo            = 1'b0;
		ioctl_download   = 1'b0;
		ioctl_index      = 8'd0;
		ioctl_wr         = 1'b0;
		ioctl_addr       = '0;
		ioctl_data       = '0;
		dio_bus_control  = 1'b0;
		disk_eject       = 2'b00;
		rom_oe_n         = 1'b1;
		ram_oe_n         = 1'b1;
		ram_we_n         = 1'b1;
		memory_uds_n     = 1'b1;
		memory_lds_n     = 1'b1;
		memory_addr      = '0;
		memory_data_out  = '0;
		dsk_read_ack_int = 1'b0;
		dsk_read_ack_ext = 1'b0;
		sdram_out        = '0;
		ticks(8);
		rst_n <= 1'b1;
		ticks(4);
		reset_req <= 1'b0;
		// 256 enables of four clocks each
		do @(negedge clk_sys); while (mac_reset_n !== 1'b1);

		// rom, second rom bank and a disk area word
		download(8'h00, 2, 100);
		download(8'h40, 1, 200);
		download(8'h03, 1, 300);
		// floppy images of both sizes, an odd size and ejects
		download(8'h01, 1, `DISK_DS_WORDS);
		download(8'h02, 1, `DISK_SS_WORDS);
		eject(2'b01);
		download(8'h01, 1, `DISK_SS_WORDS + 1);
		eject(2'b10);

		// random machine requests and bus cycles
		for (int i = 0; i < 40; i++) begin
			@(posedge clk_sys);
			r = $random(seed);
			rom_oe_n         <= r[0];
			ram_oe_n         <= r[1];
			ram_we_n         <= r[2];
			memory_uds_n     <= r[3];
			memory_lds_n     <= r[4];
			dsk_read_ack_int <= r[5] & r[6];
			dsk_read_ack_ext <= r[7] & r[8];
			cpu_as_n         <= r[9];
			cpu_fc           <= r[12:10];
			cpu_addr_hi      <= r[15:13];
			cpu_bus_control  <= r[16];
			select_rom       <= r[17];
			select_ram       <= r[18];
			turbo            <= r[19];
			memory_addr      <= 22'($random(seed));
			memory_data_out  <= 16'($random(seed));
			sdram_out        <= 16'($random(seed));
		end

		// turbo rom access, acked after the memory slot starts
		@(posedge clk_sys);
		turbo           <= 1'b1;
		cpu_as_n        <= 1'b1;
		cpu_fc          <= 3'b101;
		cpu_addr_hi     <= 3'b000;
		cpu_bus_control <= 1'b0;
		select_rom      <= 1'b1;
		select_ram      <= 1'b0;
		ticks(2);
		cpu_as_n <= 1'b0;
		ticks(3);
		cpu_bus_control <= 1'b1;
		ticks(2);
		cpu_as_n        <= 1'b1;
		cpu_bus_control <= 1'b0;
		ticks(2);
		// no memory select, acked one cycle on
		select_rom <= 1'b0;
		cpu_as_n   <= 1'b0;
		ticks(3);
		cpu_as_n <= 1'b1;
		ticks(2);
		// io region, then an interrupt acknowledge
		turbo       <= 1'b0;
		cpu_addr_hi <= `IO_REGION;
		cpu_as_n    <= 1'b0;
		ticks(2);
		cpu_addr_hi <= 3'b010;
		cpu_fc      <= 3'b111;
		ticks(2);
		cpu_as_n <= 1'b1;
		ticks(4);

		if (i_dut.i_asserts.fails == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "checks failed during the run");
		end
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
mac_pkg.sv
dl_req_if.sv
reset_sequencer.sv
bus_decode.sv
image_loader.sv
sdram_select.sv
mac_memory_top.sv
tb_mac_memory_asserts.sv
tb_mac_memory.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_mac_memory
FILELIST   := sources.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
RUN_ARGS   := +verilator+error+limit+100
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
